// ==== axiPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite widths and codes
////////////////////////////////////////////////////////////////////////////

package axiPkg;

  // address and data widths of every AXI4-Lite port in the subsystem
  localparam int axiAdrW = 32;
  localparam int axiDataW = 32;

  // one strobe bit per data byte
  localparam int axiStrbW = axiDataW / 8;

  // only the two responses that the memory can return are listed
  // okay for a normal access, slave error for an access outside the window
  typedef enum logic [1:0] {
    respOkay   = 2'd0,
    respSlvErr = 2'd2
  } respE;

endpackage

// ==== fetchPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// fetch and memory constants
////////////////////////////////////////////////////////////////////////////

package fetchPkg;

  // address and instruction width, the core is RV32 only
  localparam int xlen = 32;

  // the RAM is mapped as one window starting here
  localparam logic [xlen-1:0] memBase = 32'h8000_0000;
  localparam int memWords = 1024;
  localparam int memAdrBits = 10;

  // instruction queue between the sequencer and the predecoder
  localparam int queueDepth = 4;
  localparam int queuePtrBits = $clog2(queueDepth);

  // major opcodes that the predecoder tells apart, taken from bits 6:0
  typedef enum logic [6:0] {
    opLoad   = 7'b0000011,
    opStore  = 7'b0100011,
    opBranch = 7'b1100011,
    opJal    = 7'b1101111,
    opJalr   = 7'b1100111,
    opLui    = 7'b0110111,
    opAuipc  = 7'b0010111,
    opOpImm  = 7'b0010011,
    opOp     = 7'b0110011,
    opSystem = 7'b1110011
  } opcodeE;

  // predecode class presented with each instruction
  typedef enum logic [3:0] {
    clsLoad, clsStore, clsBranch, clsJal, clsJalr, clsLui,
    clsAuipc, clsOpImm, clsOp, clsSystem, clsCompressed, clsIllegal
  } instrClassE;

endpackage

// ==== fetchSeq.sv ====
////////////////////////////////////////////////////////////////////////////
// fetch sequencer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module fetchSeq (
  input  logic                          clk,
  input  logic                          arstN,
  // fresh start from the outside
  input  logic                          start,
  input  logic [fetchPkg::xlen-1:0]     startPc,
  output logic                          busy,
  // read master towards the instruction memory
  output logic                          arvalid,
  input  logic                          arready,
  output logic [axiPkg::axiAdrW-1:0]    araddr,
  input  logic                          rvalid,
  output logic                          rready,
  input  logic [axiPkg::axiDataW-1:0]   rdata,
  input  axiPkg::respE                  rresp,
  // queue push side
  output logic                          pushValid,
  input  logic                          pushReady,
  output logic [fetchPkg::xlen-1:0]     pushPc,
  output logic [fetchPkg::xlen-1:0]     pushInstr,
  output logic                          pushFault
);

  // idle waits for start, addr drives the AR request, data waits for R
  typedef enum logic [1:0] {
    seqIdle,
    seqAddr,
    seqData
  } seqStateE;

  seqStateE                    state;
  logic [fetchPkg::xlen-1:0]   pc;
  logic [fetchPkg::xlen-1:0]   pcStep;
  logic                        rFire;
  logic                        rFault;

  // only one read is ever in flight, so the PC is also the read address
  assign busy = (state != seqIdle);
  assign arvalid = (state == seqAddr);
  assign araddr = pc;

  // R is taken only when the queue can take the entry in the same cycle
  assign rready = (state == seqData) & pushReady;
  assign rFire = rvalid & rready;
  assign rFault = (rresp == axiPkg::respSlvErr);

  // the response is forwarded straight into the queue
  assign pushValid = (state == seqData) & rvalid;
  assign pushPc = pc;
  assign pushInstr = rdata;
  assign pushFault = rFault;

  // low bits other than 11 mark a compressed instruction
  assign pcStep = (rdata[1:0] == 2'b11) ? fetchPkg::xlen'(4) : fetchPkg::xlen'(2);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= seqIdle;
      pc <= '0;
    end else begin
      case (state)
        seqIdle: begin
          // a start while busy is ignored
          if (start) begin
            pc <= startPc;
            state <= seqAddr;
          end
        end
        seqAddr: begin
          if (arready) begin
            state <= seqData;
          end
        end
        seqData: begin
          if (rFire) begin
            // fetching stops at the first fault and busy falls
            if (rFault) begin
              state <= seqIdle;
            end else begin
              pc <= pc + pcStep;
              state <= seqAddr;
            end
          end
        end
        default: begin
          state <= seqIdle;
        end
      endcase
    end
  end

endmodule

// ==== fetchTop.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction fetch front end
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module fetchTop (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          start,
  input  logic [fetchPkg::xlen-1:0]     startPc,
  output logic                          busy,
  // loader write channel into the instruction RAM
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [axiPkg::axiAdrW-1:0]    awaddr,
  input  logic                          wvalid,
  output logic                          wready,
  input  logic [axiPkg::axiDataW-1:0]   wdata,
  input  logic [axiPkg::axiStrbW-1:0]   wstrb,
  output logic                          bvalid,
  input  logic                          bready,
  output axiPkg::respE                  bresp,
  // predecoded instruction stream
  output logic                          instrValid,
  input  logic                          instrReady,
  output logic [fetchPkg::xlen-1:0]     instrPc,
  output logic [fetchPkg::xlen-1:0]     instr,
  output fetchPkg::instrClassE          instrCls,
  output logic                          instrFault
);

  // fetch read channel between the sequencer and the RAM
  logic                          arvalid;
  logic                          arready;
  logic [axiPkg::axiAdrW-1:0]    araddr;
  logic                          rvalid;
  logic                          rready;
  logic [axiPkg::axiDataW-1:0]   rdata;
  axiPkg::respE                  rresp;
  // sequencer to queue
  logic                          pushValid;
  logic                          pushReady;
  logic [fetchPkg::xlen-1:0]     pushPc;
  logic [fetchPkg::xlen-1:0]     pushInstr;
  logic                          pushFault;
  // queue to predecoder
  logic                          popValid;
  logic                          popReady;
  logic [fetchPkg::xlen-1:0]     popPc;
  logic [fetchPkg::xlen-1:0]     popInstr;
  logic                          popFault;

  instrMem i_mem (
    .clk, .arstN,
    .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
    .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp
  );

  fetchSeq i_seq (
    .clk, .arstN, .start, .startPc, .busy,
    .arvalid, .arready, .araddr, .rvalid, .rready, .rdata, .rresp,
    .pushValid, .pushReady, .pushPc, .pushInstr, .pushFault
  );

  instrQueue i_queue (
    .clk, .arstN,
    .pushValid, .pushReady, .pushPc, .pushInstr, .pushFault,
    .popValid, .popReady, .popPc, .popInstr, .popFault
  );

  instrDecode i_decode (
    .clk, .arstN,
    .popValid, .popReady, .popPc, .popInstr, .popFault,
    .instrValid, .instrReady, .instrPc, .instr, .instrCls, .instrFault
  );

endmodule

// ==== instrDecode.sv ====
////////////////////////////////////////////////////////////////////////////
// predecode output stage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module instrDecode (
  input  logic                          clk,
  input  logic                          arstN,
  // queue head
  input  logic                          popValid,
  output logic                          popReady,
  input  logic [fetchPkg::xlen-1:0]     popPc,
  input  logic [fetchPkg::xlen-1:0]     popInstr,
  input  logic                          popFault,
  // consumer side
  output logic                          instrValid,
  input  logic                          instrReady,
  output logic [fetchPkg::xlen-1:0]     instrPc,
  output logic [fetchPkg::xlen-1:0]     instr,
  output fetchPkg::instrClassE          instrCls,
  output logic                          instrFault
);

  logic                     popFire;
  fetchPkg::instrClassE     popCls;

  // compressed detection comes first, then the major opcode
  function automatic fetchPkg::instrClassE classify(input logic [fetchPkg::xlen-1:0] ins);
    fetchPkg::instrClassE cls;
    if (ins[1:0] != 2'b11) begin
      cls = fetchPkg::clsCompressed;
    end else begin
      case (fetchPkg::opcodeE'(ins[6:0]))
        fetchPkg::opLoad:   cls = fetchPkg::clsLoad;
        fetchPkg::opStore:  cls = fetchPkg::clsStore;
        fetchPkg::opBranch: cls = fetchPkg::clsBranch;
        fetchPkg::opJal:    cls = fetchPkg::clsJal;
        fetchPkg::opJalr:   cls = fetchPkg::clsJalr;
        fetchPkg::opLui:    cls = fetchPkg::clsLui;
        fetchPkg::opAuipc:  cls = fetchPkg::clsAuipc;
        fetchPkg::opOpImm:  cls = fetchPkg::clsOpImm;
        fetchPkg::opOp:     cls = fetchPkg::clsOp;
        fetchPkg::opSystem: cls = fetchPkg::clsSystem;
        default:            cls = fetchPkg::clsIllegal;
      endcase
    end
    return cls;
  endfunction

  // the single register takes a new entry when empty or when it is being emptied
  assign popReady = ~instrValid | instrReady;
  assign popFire = popValid & popReady;

  // a faulted entry carries no usable instruction
  assign popCls = popFault ? fetchPkg::clsIllegal : classify(popInstr);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      instrValid <= 1'b0;
    end else if (popFire) begin
      instrValid <= 1'b1;
    end else if (instrReady) begin
      instrValid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (popFire) begin
      instrPc <= popPc;
      instrCls <= popCls;
      instrFault <= popFault;
      if (popFault) begin
        instr <= '0;
      end else begin
        instr <= popInstr;
      end
    end
  end

endmodule

// ==== instrMem.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction RAM with AXI4-Lite slave
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module instrMem (
  input  logic                          clk,
  input  logic                          arstN,
  // fetch read channel
  input  logic                          arvalid,
  output logic                          arready,
  input  logic [axiPkg::axiAdrW-1:0]    araddr,
  output logic                          rvalid,
  input  logic                          rready,
  output logic [axiPkg::axiDataW-1:0]   rdata,
  output axiPkg::respE                  rresp,
  // loader write channel
  input  logic                          awvalid,
  output logic                          awready,
  input  logic [axiPkg::axiAdrW-1:0]    awaddr,
  input  logic                          wvalid,
  output logic                          wready,
  input  logic [axiPkg::axiDataW-1:0]   wdata,
  input  logic [axiPkg::axiStrbW-1:0]   wstrb,
  output logic                          bvalid,
  input  logic                          bready,
  output axiPkg::respE                  bresp
);

  logic [axiPkg::axiDataW-1:0]   mem [fetchPkg::memWords];
  // one past the last mapped byte, one bit wider so it cannot wrap
  logic [fetchPkg::xlen:0]       winEnd;
  logic [fetchPkg::xlen-1:0]     rdOffset;
  logic [fetchPkg::memAdrBits-1:0] rdIdx;
  logic [fetchPkg::memAdrBits-1:0] rdIdxNext;
  logic [fetchPkg::xlen:0]       rdLastByte;
  logic                          rdFault;
  logic [axiPkg::axiDataW-1:0]   rdWord;
  logic [axiPkg::axiDataW-1:0]   rdWordNext;
  logic [axiPkg::axiDataW-1:0]   rdInstr;
  logic                          arFire;
  logic [fetchPkg::xlen-1:0]     wrOffset;
  logic [fetchPkg::memAdrBits-1:0] wrIdx;
  logic                          wrInWin;
  logic                          wrFire;

  assign winEnd = {1'b0, fetchPkg::memBase} + (fetchPkg::xlen+1)'(fetchPkg::memWords * 4);

  ////////////////////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////////////////////

  // a new address is taken only once the previous response has gone
  assign arready = ~rvalid;
  assign arFire = arvalid & arready;

  // bit 1 of the address picks the halfword, bit 0 is ignored
  assign rdOffset = araddr - fetchPkg::memBase;
  assign rdIdx = rdOffset[fetchPkg::memAdrBits+1:2];
  assign rdIdxNext = rdIdx + 1'b1;
  assign rdWord = mem[rdIdx];
  // the next word wraps at the top of the RAM, that fetch is faulted anyway
  assign rdWordNext = mem[rdIdxNext];

  // a straddling instruction takes the upper half of this word as its low half
  assign rdInstr = araddr[1] ? {rdWordNext[15:0], rdWord[31:16]} : rdWord;

  // all four bytes that the fetch may touch must lie inside the window
  assign rdLastByte = {1'b0, araddr} + 3;
  assign rdFault = (araddr < fetchPkg::memBase) | (rdLastByte >= winEnd);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      rvalid <= 1'b0;
    end else if (arFire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // response payload, held while rvalid waits for rready
  always_ff @(posedge clk) begin
    if (arFire) begin
      if (rdFault) begin
        rdata <= '0;
        rresp <= axiPkg::respSlvErr;
      end else begin
        rdata <= rdInstr;
        rresp <= axiPkg::respOkay;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////////////

  // address and data are taken together and only with no response pending
  assign awready = wvalid & ~bvalid;
  assign wready = awvalid & ~bvalid;
  assign wrFire = awvalid & wvalid & ~bvalid;

  assign wrOffset = awaddr - fetchPkg::memBase;
  assign wrIdx = wrOffset[fetchPkg::memAdrBits+1:2];
  assign wrInWin = (awaddr >= fetchPkg::memBase) & ({1'b0, awaddr} < winEnd);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      bvalid <= 1'b0;
    end else if (wrFire) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wrFire) begin
      if (wrInWin) begin
        bresp <= axiPkg::respOkay;
      end else begin
        bresp <= axiPkg::respSlvErr;
      end
    end
  end

  // byte lanes enabled by wstrb, an out of window write changes nothing
  always_ff @(posedge clk) begin
    if (wrFire && wrInWin) begin
      for (int b = 0; b < axiPkg::axiStrbW; b++) begin
        if (wstrb[b]) begin
          mem[wrIdx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

// ==== instrQueue.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction queue
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module instrQueue (
  input  logic                          clk,
  input  logic                          arstN,
  input  logic                          pushValid,
  output logic                          pushReady,
  input  logic [fetchPkg::xlen-1:0]     pushPc,
  input  logic [fetchPkg::xlen-1:0]     pushInstr,
  input  logic                          pushFault,
  output logic                          popValid,
  input  logic                          popReady,
  output logic [fetchPkg::xlen-1:0]     popPc,
  output logic [fetchPkg::xlen-1:0]     popInstr,
  output logic                          popFault
);

  logic [fetchPkg::xlen-1:0]         pcBuf    [fetchPkg::queueDepth];
  logic [fetchPkg::xlen-1:0]         instrBuf [fetchPkg::queueDepth];
  logic                              faultBuf [fetchPkg::queueDepth];
  logic [fetchPkg::queuePtrBits-1:0] wrPtr;
  logic [fetchPkg::queuePtrBits-1:0] rdPtr;
  logic [fetchPkg::queuePtrBits:0]   count;
  logic                              full;
  logic                              pushFire;
  logic                              popFire;

  assign full = (count == (fetchPkg::queuePtrBits+1)'(fetchPkg::queueDepth));
  // a full queue still takes a push when the head leaves in the same cycle
  assign pushReady = ~full | popReady;
  assign popValid = (count != '0);
  assign pushFire = pushValid & pushReady;
  assign popFire = popValid & popReady;

  // the head is read straight from storage
  assign popPc = pcBuf[rdPtr];
  assign popInstr = instrBuf[rdPtr];
  assign popFault = faultBuf[rdPtr];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (pushFire) begin
        wrPtr <= (wrPtr == fetchPkg::queuePtrBits'(fetchPkg::queueDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (popFire) begin
        rdPtr <= (rdPtr == fetchPkg::queuePtrBits'(fetchPkg::queueDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      // count only moves when exactly one side fires
      if (pushFire && !popFire) begin
        count <= count + 1'b1;
      end else if (popFire && !pushFire) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pushFire) begin
      pcBuf[wrPtr] <= pushPc;
      instrBuf[wrPtr] <= pushInstr;
      faultBuf[wrPtr] <= pushFault;
    end
  end

endmodule

// ==== project.f ====
fetchPkg.sv
axiPkg.sv
instrMem.sv
fetchSeq.sv
instrQueue.sv
instrDecode.sv
fetchTop.sv
tbFetchTop.sv

// ==== tbFetchTop.sv ====
////////////////////////////////////////////////////////////////////////////
// fetch front end testbench
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tbFetchTop;

  localparam int hwCount = 2 * fetchPkg::memWords;
  // one past the last mapped byte and one bit wider so it cannot wrap
  localparam logic [32:0] winEnd = {1'b0, fetchPkg::memBase} + 33'(fetchPkg::memWords * 4);

  // one expected output entry with the PC that the walk goes on from
  typedef struct packed {
    logic [31:0]          pc;
    logic [31:0]          ins;
    fetchPkg::instrClassE cls;
    logic                 fault;
    logic [31:0]          nextPc;
  } expT;

  logic clk;
  logic arstN;
  logic start;
  logic [31:0] startPc;
  logic busy;
  logic awvalid;
  logic awready;
  logic [31:0] awaddr;
  logic wvalid;
  logic wready;
  logic [31:0] wdata;
  logic [3:0] wstrb;
  logic bvalid;
  logic bready;
  axiPkg::respE bresp;
  logic instrValid;
  logic instrReady;
  logic [31:0] instrPc;
  logic [31:0] instr;
  fetchPkg::instrClassE instrCls;
  logic instrFault;

  logic [31:0] img [fetchPkg::memWords];
  logic [15:0] hw [hwCount];
  logic [6:0] opTable [12];
  expT expQ [$];
  integer seed = 99215;
  logic [31:0] rnd;
  logic stallMode = 1'b0;
  int stallLeft = 0;
  int cycles = 0;
  int cycleLimit;
  int straddles;
  int walkLen;

  fetchTop i_dut (
    .clk, .arstN, .start, .startPc, .busy,
    .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
    .bvalid, .bready, .bresp,
    .instrValid, .instrReady, .instrPc, .instr, .instrCls, .instrFault
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic checkVal(input string name, input logic [31:0] expVal, input logic [31:0] actVal);
    if (actVal !== expVal) begin
      failRun($sformatf("** Error at %0t ns: %s expected 0x%h, got 0x%h",
                        $time, name, expVal, actVal));
    end
  endtask

  // class from the low two bits first and then from the major opcode
  function automatic fetchPkg::instrClassE refClass(input logic [31:0] ins);
    fetchPkg::instrClassE cls;
    if (ins[1:0] != 2'b11) begin
      cls = fetchPkg::clsCompressed;
    end else begin
      case (ins[6:0])
        7'b0000011: cls = fetchPkg::clsLoad;
        7'b0100011: cls = fetchPkg::clsStore;
        7'b1100011: cls = fetchPkg::clsBranch;
        7'b1101111: cls = fetchPkg::clsJal;
        7'b1100111: cls = fetchPkg::clsJalr;
        7'b0110111: cls = fetchPkg::clsLui;
        7'b0010111: cls = fetchPkg::clsAuipc;
        7'b0010011: cls = fetchPkg::clsOpImm;
        7'b0110011: cls = fetchPkg::clsOp;
        7'b1110011: cls = fetchPkg::clsSystem;
        default:    cls = fetchPkg::clsIllegal;
      endcase
    end
    return cls;
  endfunction

  // expected result of one fetch at pc as the testbench image gives it
  function automatic expT refStep(input logic [31:0] pc);
    expT e;
    logic [31:0] off;
    int idx;
    e.pc = pc;
    off = pc - fetchPkg::memBase;
    idx = int'(off[31:2]);
    e.fault = (pc < fetchPkg::memBase) || (({1'b0, pc} + 33'd3) >= winEnd);
    if (e.fault) begin
      e.ins = '0;
      e.cls = fetchPkg::clsIllegal;
      e.nextPc = pc;
    end else begin
      // a fetch at bit 1 set joins the upper half of one word to the next word
      if (pc[1]) begin
        e.ins = {img[idx+1][15:0], img[idx][31:16]};
      end else begin
        e.ins = img[idx];
      end
      e.cls = refClass(e.ins);
      e.nextPc = pc + ((e.ins[1:0] == 2'b11) ? 32'd4 : 32'd2);
    end
    return e;
  endfunction

  // walk from pc up to and including the first faulted entry
  task automatic buildExpected(input logic [31:0] pc);
    expT e;
    e = refStep(pc);
    expQ.push_back(e);
    while (!e.fault) begin
      e = refStep(e.nextPc);
      expQ.push_back(e);
      if (!e.fault && e.pc[1] && e.ins[1:0] == 2'b11) begin
        straddles++;
      end
    end
  endtask

  // a halfword stream of mixed 16 and 32 bit instructions packed into words
  task automatic buildImage();
    int i;
    logic [31:0] w;
    opTable = '{7'b0000011, 7'b0100011, 7'b1100011, 7'b1101111, 7'b1100111, 7'b0110111,
                7'b0010111, 7'b0010011, 7'b0110011, 7'b1110011, 7'b0001011, 7'b1011011};
    i = 0;
    // no instruction covers the last halfword, so the walk from the base always lands on it
    while (i < hwCount - 1) begin
      rnd = $random(seed);
      w = $random(seed);
      if (rnd[0] || i + 2 >= hwCount) begin
        if (w[1:0] == 2'b11) begin
          w[1:0] = 2'b01;
        end
        hw[i] = w[15:0];
        i = i + 1;
      end else begin
        // the last two table entries are not RV32 opcodes and must be illegal
        w[6:0] = opTable[rnd[7:4] % 12];
        hw[i] = w[15:0];
        hw[i+1] = w[31:16];
        i = i + 2;
      end
    end
    // low half of a 32-bit instruction whose upper half lies past the window
    hw[hwCount-1] = {w[15:7], 7'b0010011};
    for (int k = 0; k < fetchPkg::memWords; k++) begin
      img[k] = {hw[2*k+1], hw[2*k]};
    end
  endtask

  // one AXI4-Lite write with AW and W together and then a wait for the B response
  task automatic writeWord(input logic [31:0] adr, input logic [31:0] data,
                           input logic [3:0] strb, input axiPkg::respE expResp);
    logic done;
    @(negedge clk);
    awvalid = 1'b1;
    awaddr = adr;
    wvalid = 1'b1;
    wdata = data;
    wstrb = strb;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = awready & wready;
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    bready = 1'b1;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = bvalid;
    end
    checkVal("bresp", 32'(expResp), 32'(bresp));
    @(negedge clk);
    bready = 1'b0;
  endtask

  // every fifth word lands in two halves with byte strobes and junk in the masked lanes
  task automatic loadImage();
    logic [31:0] adr;
    for (int k = 0; k < fetchPkg::memWords; k++) begin
      adr = fetchPkg::memBase + 32'(4 * k);
      if (k % 5 == 2) begin
        writeWord(adr, {~img[k][31:16], img[k][15:0]}, 4'b0011, axiPkg::respOkay);
        writeWord(adr, {img[k][31:16], ~img[k][15:0]}, 4'b1100, axiPkg::respOkay);
      end else begin
        writeWord(adr, img[k], 4'b1111, axiPkg::respOkay);
      end
    end
  endtask

  // start at pc and wait until every expected entry came out and busy fell
  task automatic runFetch(input logic [31:0] pc, input logic stall);
    buildExpected(pc);
    stallMode = stall;
    @(negedge clk);
    start = 1'b1;
    startPc = pc;
    @(negedge clk);
    start = 1'b0;
    // the sequencer leaves idle on the edge that takes the start
    checkVal("busy", 32'd1, 32'(busy));
    while (expQ.size() != 0 || busy) begin
      @(negedge clk);
    end
    // nothing may follow the faulted entry
    repeat (10) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // consumer side
  ////////////////////////////////////////////////////////////////////////////

  // random stretches of low instrReady when stalling is on
  always @(negedge clk) begin
    if (!stallMode) begin
      instrReady = 1'b1;
    end else if (stallLeft > 0) begin
      instrReady = 1'b0;
      stallLeft--;
    end else begin
      rnd = $random(seed);
      instrReady = (rnd[1:0] != 2'b00);
      if (rnd[1:0] == 2'b00) begin
        stallLeft = int'(rnd[5:2]);
      end
    end
  end

  always @(posedge clk) begin : compareOutput
    expT e;
    if (arstN && instrValid && instrReady) begin
      if (expQ.size() == 0) begin
        failRun("an instruction came out where none was expected");
      end else begin
        e = expQ.pop_front();
        checkVal("instrPc", e.pc, instrPc);
        checkVal("instr", e.ins, instr);
        checkVal("instrCls", 32'(e.cls), 32'(instrCls));
        checkVal("instrFault", 32'(e.fault), 32'(instrFault));
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycleLimit) begin
      failRun($sformatf("timeout, the run did not finish within %0d cycles", cycleLimit));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    arstN = 1'b0;
    start = 1'b0;
    startPc = '0;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b0;
    instrReady = 1'b1;
    straddles = 0;
    buildImage();
    // the full walk sizes the limit for two runs through memory and one short run
    buildExpected(fetchPkg::memBase);
    walkLen = expQ.size();
    expQ.delete();
    cycleLimit = 20 * (2 * walkLen + 1) + 5 * (2 * fetchPkg::memWords + 1) + 20;
    if (straddles == 0) begin
      failRun("the program image holds no straddling 32-bit instruction");
    end
    repeat (3) @(negedge clk);
    arstN = 1'b1;
    loadImage();
    // a write below the window is dropped and the last word keeps its image value
    writeWord(fetchPkg::memBase - 32'd4, ~img[fetchPkg::memWords-1], 4'b1111,
              axiPkg::respSlvErr);
    runFetch(fetchPkg::memBase, 1'b0);
    runFetch(fetchPkg::memBase, 1'b1);
    runFetch(fetchPkg::memBase - 32'd8, 1'b0);
    $display("TB PASSED");
    $finish;
  end

endmodule
